//--- logic/ra_defs.svh
// Register counts, widths and fixed register numbers
// for the register access stage
`ifndef RA_DEFS_SVH
`define RA_DEFS_SVH

// Register file sizes
`define RA_NUM_GPR 8
`define RA_NUM_SEG 6
`define RA_NUM_MMX 8

// Register and field widths
`define RA_GPR_W 32
`define RA_SEG_W 16
`define RA_MMX_W 64
`define RA_REG_NUM_W 3
`define RA_IMM_W 48

// Architectural register numbers
`define RA_ESP_NUM 4
`define RA_SS_NUM 2

`endif

//--- logic/ra_pkg.sv
// Types of the register access stage: operand, stack and size enums,
// decoded and issued instruction records, writeback records
`include "ra_defs.svh"

package ra_pkg;

    typedef enum logic [2:0] {
        OP_NONE      = 3'd0,
        OP_FIXED_REG = 3'd1,
        OP_IMM       = 3'd2,
        OP_MEM       = 3'd3,
        OP_MODRM_REG = 3'd4
    } operand_kind_e;

    // Bit 0 push, bit 1 pop
    typedef enum logic [1:0] {
        STACK_NONE = 2'd0,
        STACK_PUSH = 2'd1,
        STACK_POP  = 2'd2
    } stack_op_e;

    typedef enum logic [1:0] {
        SIZE_BYTE  = 2'd0,
        SIZE_WORD  = 2'd1,
        SIZE_DWORD = 2'd2
    } access_size_e;

    typedef logic [`RA_REG_NUM_W-1:0] reg_num_t;

    typedef logic [`RA_NUM_GPR-1:0][`RA_GPR_W-1:0] gpr_array_t;
    typedef logic [`RA_NUM_SEG-1:0][`RA_SEG_W-1:0] seg_array_t;
    typedef logic [`RA_NUM_MMX-1:0][`RA_MMX_W-1:0] mmx_array_t;

    typedef struct packed {
        access_size_e        size;
        operand_kind_e       op0_kind;
        reg_num_t            op0_reg;
        operand_kind_e       op1_kind;
        reg_num_t            op1_reg;
        logic                dest_valid;
        reg_num_t            dest_reg;
        logic [7:0]          modrm;
        logic [7:0]          sib;
        logic [`RA_IMM_W-1:0] imm;
        logic [31:0]         disp;
        logic [3:0]          alu_op;
        stack_op_e           stack_op;
        logic [15:0]         opcode;
        logic [31:0]         pc;
    } decoded_instr_t;

    typedef struct packed {
        decoded_instr_t      dec;
        reg_num_t            op0_num;
        reg_num_t            op1_num;
        logic [`RA_GPR_W-1:0] op0_value;
        logic [`RA_GPR_W-1:0] op1_value;
        logic [31:0]         stack_address;
        seg_array_t          seg_values;
        mmx_array_t          mmx_values;
    } issued_instr_t;

    typedef struct packed {
        logic                en;
        reg_num_t            num;
        access_size_e        size;
        logic                stack;
        logic [`RA_GPR_W-1:0] data;
    } gpr_wb_t;

    typedef struct packed {
        logic                en;
        reg_num_t            num;
        logic [`RA_SEG_W-1:0] data;
    } seg_wb_t;

    typedef struct packed {
        logic                en;
        reg_num_t            num;
        logic [`RA_MMX_W-1:0] data;
    } mmx_wb_t;

    // Operand kinds that read a general register
    function automatic logic is_reg_operand(operand_kind_e kind);
        return (kind == OP_FIXED_REG) || (kind == OP_MODRM_REG);
    endfunction

endpackage

//--- logic/gpr_file.sv
// General register file, eight 32-bit registers
// Byte, word and dword writeback, all registers visible at once
`timescale 1ns/1ns

module gpr_file
    import ra_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  gpr_wb_t    wb,
    output gpr_array_t values
);

    gpr_array_t regs_q;
    logic [31:0] old_value;
    logic [31:0] merged;

    assign old_value = regs_q[wb.num];

    // Partial writes keep the upper bits of the old value
    always_comb begin
        merged = old_value;
        case (wb.size)
            SIZE_BYTE: begin
                merged[7:0] = wb.data[7:0];
            end
            SIZE_WORD: begin
                merged[15:0] = wb.data[15:0];
            end
            default: begin
                merged = wb.data;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            regs_q <= '0;
        end else if (wb.en) begin
            regs_q[wb.num] <= merged;
        end
    end

    assign values = regs_q;

endmodule

//--- logic/segment_register_file.sv
// Segment register file
// es, cs, ss, ds, fs, gs as numbers 0 to 5, full-width writeback
`timescale 1ns/1ns

module segment_register_file
    import ra_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  seg_wb_t    wb,
    output seg_array_t values
);

    `include "ra_defs.svh"

    seg_array_t regs_q;
    logic       wr_en;

    // Numbers 6 and 7 name no register
    assign wr_en = wb.en && (wb.num < `RA_REG_NUM_W'(`RA_NUM_SEG));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            regs_q <= '0;
        end else if (wr_en) begin
            regs_q[wb.num] <= wb.data;
        end
    end

    assign values = regs_q;

endmodule

//--- logic/mmx_register_file.sv
// MMX register file, eight 64-bit registers
// Full-width writeback only
`timescale 1ns/1ns

module mmx_register_file
    import ra_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  mmx_wb_t    wb,
    output mmx_array_t values
);

    mmx_array_t regs_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            regs_q <= '0;
        end else if (wb.en) begin
            regs_q[wb.num] <= wb.data;
        end
    end

    assign values = regs_q;

endmodule

//--- logic/operand_scoreboard.sv
// Pending-write bits for the general registers
// Raises hazard when the offered instruction reads a pending register
`timescale 1ns/1ns

module operand_scoreboard
    import ra_pkg::*;
(
    input  logic           clk,
    input  logic           rst_n,
    input  logic           flush,
    input  logic           issue,
    input  decoded_instr_t instr,
    input  reg_num_t       op0_num,
    input  reg_num_t       op1_num,
    input  gpr_wb_t        wb,
    output logic           hazard
);

    `include "ra_defs.svh"

    logic [`RA_NUM_GPR-1:0] pending_q;
    logic [`RA_NUM_GPR-1:0] pending_d;
    logic op0_busy;
    logic op1_busy;
    logic esp_busy;

    assign op0_busy = is_reg_operand(instr.op0_kind) && pending_q[op0_num];
    assign op1_busy = is_reg_operand(instr.op1_kind) && pending_q[op1_num];

    // Push and pop read ESP even without an ESP operand
    assign esp_busy = (instr.stack_op != STACK_NONE) && pending_q[`RA_ESP_NUM];

    assign hazard = op0_busy || op1_busy || esp_busy;

    always_comb begin
        pending_d = pending_q;
        if (wb.en) begin
            pending_d[wb.num] = 1'b0;
        end
        // A new destination overrides a same-edge writeback
        if (issue && instr.dest_valid) begin
            pending_d[instr.dest_reg] = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending_q <= '0;
        end else if (flush) begin
            pending_q <= '0;
        end else begin
            pending_q <= pending_d;
        end
    end

endmodule

//--- logic/stack_pointer_tracker.sv
// Speculative stack pointer for push and pop
// Stack address is SS * 16 plus the pointer seen by the instruction
`timescale 1ns/1ns

module stack_pointer_tracker
    import ra_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  logic         flush,
    input  logic         issue,
    input  stack_op_e    stack_op,
    input  access_size_e size,
    input  logic [15:0]  ss,
    input  logic [31:0]  committed_esp,
    input  gpr_wb_t      wb,
    output logic [31:0]  stack_address
);

    `include "ra_defs.svh"

    logic [31:0] sp_q;
    logic [31:0] sp_cur;
    logic [31:0] sp_next;
    logic [31:0] step;
    logic [31:0] push_sp;
    logic [31:0] pop_sp;
    logic [31:0] seg_base;
    logic        esp_wb;
    logic        reload_q;

    // Only non-stack ESP writes resync the pointer
    assign esp_wb = wb.en && !wb.stack && (wb.num == `RA_REG_NUM_W'(`RA_ESP_NUM));

    // The register file holds the new ESP one edge after the write,
    // so the pointer follows it directly during that cycle
    assign sp_cur = reload_q ? committed_esp : sp_q;

    assign step    = (size == SIZE_DWORD) ? 32'd4 : 32'd2;
    assign push_sp = sp_cur - step;
    assign pop_sp  = sp_cur + step;

    assign seg_base      = {12'd0, ss, 4'd0};
    assign stack_address = seg_base + ((stack_op == STACK_PUSH) ? push_sp : sp_cur);

    always_comb begin
        sp_next = sp_cur;
        if (issue) begin
            case (stack_op)
                STACK_PUSH: sp_next = push_sp;
                STACK_POP:  sp_next = pop_sp;
                default:    sp_next = sp_cur;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sp_q     <= '0;
            reload_q <= 1'b0;
        end else begin
            // Flush also takes the committed ESP in the next cycle
            reload_q <= flush || esp_wb;
            sp_q     <= sp_next;
        end
    end

endmodule

//--- logic/register_access_stage.sv
// Register access stage top level
// Operand register selection, register file reads, stall control
// and the single output register towards address generation
`timescale 1ns/1ns

module register_access_stage
    import ra_pkg::*;
(
    input  logic           clk,
    input  logic           rst_n,
    input  logic           flush,

    // Decode side
    input  logic           d_valid,
    output logic           d_ready,
    input  decoded_instr_t d_instr,

    // Address generation side
    output logic           r_valid,
    input  logic           r_ready,
    output issued_instr_t  r_instr,

    // Writebacks
    input  gpr_wb_t        wb_gpr,
    input  seg_wb_t        wb_seg,
    input  mmx_wb_t        wb_mmx
);

    `include "ra_defs.svh"

    gpr_array_t    gpr_values;
    seg_array_t    seg_values;
    mmx_array_t    mmx_values;
    reg_num_t      op0_num;
    reg_num_t      op1_num;
    logic [31:0]   stack_address;
    logic          hazard;
    logic          accept;
    issued_instr_t issued;

    // modrm.rm for register-form operands, decoded field for fixed ones
    function automatic reg_num_t resolve_num(operand_kind_e kind, reg_num_t fixed_reg,
                                             logic [7:0] modrm);
        case (kind)
            OP_MODRM_REG: return modrm[2:0];
            OP_FIXED_REG: return fixed_reg;
            default:      return '0;
        endcase
    endfunction

    assign op0_num = resolve_num(d_instr.op0_kind, d_instr.op0_reg, d_instr.modrm);
    assign op1_num = resolve_num(d_instr.op1_kind, d_instr.op1_reg, d_instr.modrm);

    // Hold off while an operand is pending or the output slot stays full
    assign d_ready = !flush && !hazard && (!r_valid || r_ready);
    assign accept  = d_valid && d_ready;

    always_comb begin
        issued               = '0;
        issued.dec           = d_instr;
        issued.op0_num       = op0_num;
        issued.op1_num       = op1_num;
        issued.op0_value     = is_reg_operand(d_instr.op0_kind) ? gpr_values[op0_num] : '0;
        issued.op1_value     = is_reg_operand(d_instr.op1_kind) ? gpr_values[op1_num] : '0;
        issued.stack_address = stack_address;
        issued.seg_values    = seg_values;
        issued.mmx_values    = mmx_values;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            r_valid <= 1'b0;
        end else if (flush) begin
            r_valid <= 1'b0;
        end else if (accept) begin
            r_valid <= 1'b1;
        end else if (r_ready) begin
            r_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            r_instr <= issued;
        end
    end

    gpr_file u_gpr_file (
        .clk    (clk),
        .rst_n  (rst_n),
        .wb     (wb_gpr),
        .values (gpr_values)
    );

    segment_register_file u_segment_register_file (
        .clk    (clk),
        .rst_n  (rst_n),
        .wb     (wb_seg),
        .values (seg_values)
    );

    mmx_register_file u_mmx_register_file (
        .clk    (clk),
        .rst_n  (rst_n),
        .wb     (wb_mmx),
        .values (mmx_values)
    );

    operand_scoreboard u_operand_scoreboard (
        .clk     (clk),
        .rst_n   (rst_n),
        .flush   (flush),
        .issue   (accept),
        .instr   (d_instr),
        .op0_num (op0_num),
        .op1_num (op1_num),
        .wb      (wb_gpr),
        .hazard  (hazard)
    );

    stack_pointer_tracker u_stack_pointer_tracker (
        .clk           (clk),
        .rst_n         (rst_n),
        .flush         (flush),
        .issue         (accept),
        .stack_op      (d_instr.stack_op),
        .size          (d_instr.size),
        .ss            (seg_values[`RA_SS_NUM]),
        .committed_esp (gpr_values[`RA_ESP_NUM]),
        .wb            (wb_gpr),
        .stack_address (stack_address)
    );

endmodule

//--- dv/register_access_tb.sv
// Testbench for the register access stage
// LFSR stimulus, reference model of registers, pending bits and stack pointer
`timescale 1ns/1ns

module register_access_tb
    import ra_pkg::*;
();

    `include "ra_defs.svh"

    localparam int NUM_INSTR  = 400;
    localparam int CLK_PERIOD = 4;

    logic           clk = 1'b0;
    logic           rst_n;
    logic           flush;
    logic           d_valid;
    logic           d_ready;
    decoded_instr_t d_instr;
    logic           r_valid;
    logic           r_ready;
    issued_instr_t  r_instr;
    gpr_wb_t        wb_gpr;
    seg_wb_t        wb_seg;
    mmx_wb_t        wb_mmx;

    // Reference model state
    gpr_array_t             gpr_m;
    seg_array_t             seg_m;
    mmx_array_t             mmx_m;
    logic [`RA_NUM_GPR-1:0] pend_m;
    logic [31:0]            sp_m;
    logic                   r_valid_m;
    issued_instr_t          exp_q[$];
    logic [16:0]            lfsr = 17'd66027;
    int                     accepted;

    always #(CLK_PERIOD / 2) clk = ~clk;

    register_access_stage dut_i (.*);

    // Fibonacci LFSR, taps 17 and 14
    function automatic logic [16:0] lfsr_step(input logic [16:0] s);
        return {s[15:0], s[16] ^ s[13]};
    endfunction

    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            r = {r[62:0], lfsr[0]};
        end
        return r;
    endfunction

    task automatic stop_with_failure();
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic verify_handshake(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("FAILED %s expected %b actual %b", name, exp, act);
            stop_with_failure();
        end
    endtask

    task automatic check_stack_address(input string name, input logic [31:0] exp,
                                       input logic [31:0] act);
        if (exp !== act) begin
            $display("FAILED %s expected %h actual %h", name, exp, act);
            stop_with_failure();
        end
    endtask

    // Whole record apart from the stack address, which has its own check
    task automatic compare_record(input string name, input issued_instr_t exp,
                                  input issued_instr_t act);
        exp.stack_address = '0;
        act.stack_address = '0;
        if (exp !== act) begin
            $display("FAILED %s expected %h actual %h", name, exp, act);
            stop_with_failure();
        end
    endtask

    function automatic logic names_register(input operand_kind_e kind);
        return (kind == OP_FIXED_REG) || (kind == OP_MODRM_REG);
    endfunction

    // modrm.rm for register-form operands, decoded field for fixed ones
    function automatic reg_num_t operand_reg(input operand_kind_e kind, input reg_num_t field,
                                             input logic [7:0] modrm);
        if (kind == OP_MODRM_REG) begin
            return modrm[2:0];
        end
        if (kind == OP_FIXED_REG) begin
            return field;
        end
        return '0;
    endfunction

    function automatic logic model_hazard(input decoded_instr_t di);
        reg_num_t n0;
        reg_num_t n1;
        n0 = operand_reg(di.op0_kind, di.op0_reg, di.modrm);
        n1 = operand_reg(di.op1_kind, di.op1_reg, di.modrm);
        return (names_register(di.op0_kind) && pend_m[n0])
            || (names_register(di.op1_kind) && pend_m[n1])
            || ((di.stack_op != STACK_NONE) && pend_m[`RA_ESP_NUM]);
    endfunction

    function automatic issued_instr_t expected_record(input decoded_instr_t di);
        issued_instr_t e;
        logic [31:0]   step;
        e = '0;
        e.dec = di;
        e.op0_num = operand_reg(di.op0_kind, di.op0_reg, di.modrm);
        e.op1_num = operand_reg(di.op1_kind, di.op1_reg, di.modrm);
        e.op0_value = names_register(di.op0_kind) ? gpr_m[e.op0_num] : '0;
        e.op1_value = names_register(di.op1_kind) ? gpr_m[e.op1_num] : '0;
        step = (di.size == SIZE_DWORD) ? 32'd4 : 32'd2;
        e.stack_address = 32'(seg_m[`RA_SS_NUM]) * 32'd16
                        + ((di.stack_op == STACK_PUSH) ? sp_m - step : sp_m);
        e.seg_values = seg_m;
        e.mmx_values = mmx_m;
        return e;
    endfunction

    function automatic decoded_instr_t random_instr();
        decoded_instr_t di;
        logic [2:0]     k0;
        logic [2:0]     k1;
        logic [1:0]     so;
        logic [1:0]     sz;
        k0 = 3'(rand_bits(3));
        k1 = 3'(rand_bits(3));
        so = 2'(rand_bits(2));
        sz = 2'(rand_bits(2));
        di.size       = access_size_e'((sz == 2'd3) ? 2'd2 : sz);
        di.op0_kind   = operand_kind_e'((k0 > 3'd4) ? k0 - 3'd4 : k0);
        di.op0_reg    = 3'(rand_bits(3));
        di.op1_kind   = operand_kind_e'((k1 > 3'd4) ? k1 - 3'd4 : k1);
        di.op1_reg    = 3'(rand_bits(3));
        di.dest_valid = 1'(rand_bits(1));
        di.dest_reg   = 3'(rand_bits(3));
        di.modrm      = 8'(rand_bits(8));
        di.sib        = 8'(rand_bits(8));
        di.imm        = 48'(rand_bits(48));
        di.disp       = 32'(rand_bits(32));
        di.alu_op     = 4'(rand_bits(4));
        di.stack_op   = stack_op_e'((so == 2'd3) ? 2'd0 : so);
        di.opcode     = 16'(rand_bits(16));
        di.pc         = 32'(rand_bits(32));
        return di;
    endfunction

    // Called at the falling edge; an offer is held until it is taken
    task automatic drive_inputs(input logic taken);
        logic [1:0] sz;
        logic [2:0] sn;
        if (!d_valid || taken) begin
            d_valid = (accepted < NUM_INSTR) && (rand_bits(2) != 64'd0);
            d_instr = random_instr();
        end
        wb_gpr.en = 1'(rand_bits(1));
        wb_gpr.num = 3'(rand_bits(3));
        // Steer half the writebacks to a pending register so stalls resolve
        if ((pend_m != '0) && (rand_bits(1) != 64'd0)) begin
            while (!pend_m[wb_gpr.num]) begin
                wb_gpr.num = wb_gpr.num + 3'd1;
            end
        end
        sz = 2'(rand_bits(2));
        wb_gpr.size  = access_size_e'((sz == 2'd3) ? 2'd2 : sz);
        wb_gpr.stack = (rand_bits(2) == 64'd3);
        wb_gpr.data  = 32'(rand_bits(32));
        sn = 3'(rand_bits(3));
        wb_seg.en   = (rand_bits(2) == 64'd0);
        wb_seg.num  = (sn > 3'd5) ? sn - 3'd2 : sn;
        wb_seg.data = 16'(rand_bits(16));
        wb_mmx.en   = (rand_bits(2) == 64'd0);
        wb_mmx.num  = 3'(rand_bits(3));
        wb_mmx.data = rand_bits(64);
        r_ready = (rand_bits(2) != 64'd0);
        flush   = (rand_bits(5) == 64'd0);
    endtask

    // Advance the model over one rising edge
    task automatic apply_edge(input logic accept);
        issued_instr_t e;
        logic [31:0]   step;
        e = expected_record(d_instr);
        if (r_valid_m && r_ready) begin
            void'(exp_q.pop_front());
        end
        if (flush) begin
            r_valid_m = 1'b0;
            exp_q.delete();
        end else if (accept) begin
            r_valid_m = 1'b1;
            exp_q.push_back(e);
            accepted++;
        end else if (r_ready) begin
            r_valid_m = 1'b0;
        end
        if (wb_gpr.en) begin
            case (wb_gpr.size)
                SIZE_BYTE: gpr_m[wb_gpr.num][7:0] = wb_gpr.data[7:0];
                SIZE_WORD: gpr_m[wb_gpr.num][15:0] = wb_gpr.data[15:0];
                default:   gpr_m[wb_gpr.num] = wb_gpr.data;
            endcase
        end
        if (wb_seg.en) begin
            seg_m[wb_seg.num] = wb_seg.data;
        end
        if (wb_mmx.en) begin
            mmx_m[wb_mmx.num] = wb_mmx.data;
        end
        if (flush) begin
            pend_m = '0;
        end else begin
            if (wb_gpr.en) begin
                pend_m[wb_gpr.num] = 1'b0;
            end
            // Issue wins over a same-edge writeback
            if (accept && d_instr.dest_valid) begin
                pend_m[d_instr.dest_reg] = 1'b1;
            end
        end
        step = (d_instr.size == SIZE_DWORD) ? 32'd4 : 32'd2;
        if (accept && (d_instr.stack_op == STACK_PUSH)) begin
            sp_m = sp_m - step;
        end else if (accept && (d_instr.stack_op == STACK_POP)) begin
            sp_m = sp_m + step;
        end
        if (flush || (wb_gpr.en && !wb_gpr.stack && (wb_gpr.num == 3'(`RA_ESP_NUM)))) begin
            sp_m = gpr_m[`RA_ESP_NUM];
        end
    endtask

    task automatic sample_outputs(output logic accept);
        logic          exp_ready;
        issued_instr_t head;
        exp_ready = !flush && !model_hazard(d_instr) && (!r_valid_m || r_ready);
        verify_handshake("stall decision d_ready", exp_ready, d_ready);
        verify_handshake("output valid r_valid", r_valid_m, r_valid);
        if (r_valid_m) begin
            head = exp_q[0];
            check_stack_address("stack address", head.stack_address, r_instr.stack_address);
            compare_record("issued record", head, r_instr);
        end
        accept = d_valid && d_ready;
    endtask

    initial begin
        repeat (NUM_INSTR * 40) @(posedge clk);
        $display("Timeout: the stage stopped accepting or issuing instructions");
        stop_with_failure();
    end

    initial begin
        logic accept;
        rst_n     = 1'b0;
        flush     = 1'b0;
        d_valid   = 1'b0;
        d_instr   = '0;
        r_ready   = 1'b0;
        wb_gpr    = '0;
        wb_seg    = '0;
        wb_mmx    = '0;
        gpr_m     = '0;
        seg_m     = '0;
        mmx_m     = '0;
        pend_m    = '0;
        sp_m      = '0;
        r_valid_m = 1'b0;
        accepted  = 0;
        accept    = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        while ((accepted < NUM_INSTR) || (exp_q.size() != 0)) begin
            drive_inputs(accept);
            // Settle combinational outputs before the rising edge
            #1;
            sample_outputs(accept);
            apply_edge(accept);
            @(negedge clk);
        end
        $display("Testbench passed");
        $finish;
    end

endmodule

//--- all.f
+incdir+logic
logic/ra_pkg.sv
logic/gpr_file.sv
logic/segment_register_file.sv
logic/mmx_register_file.sv
logic/operand_scoreboard.sv
logic/stack_pointer_tracker.sv
logic/register_access_stage.sv
dv/register_access_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the register access testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --timescale 1ns/1ns -f all.f \
    --top-module register_access_tb -o register_access_tb
out=$(./obj_dir/register_access_tb 2>&1 || true)
echo "$out"
if echo "$out" | grep -qx "Testbench passed"; then
    exit 0
fi
exit 1
